// File: include/len5_consts.svh
// Global widths and default predictor sizes for the fetch stage
`ifndef LEN5_CONSTS_SVH
`define LEN5_CONSTS_SVH

// ----------------------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------------------

// Address width
`define XLEN 32
// Instruction word width
`define ILEN 32

// ----------------------------------------------------------------------
// Branch predictor geometry
// ----------------------------------------------------------------------

// Global history length in bits
`define HLEN_DEFAULT 4
// BTB index bits, so 16 entries by default
`define BTB_BITS_DEFAULT 4

`endif

// File: verilog/fetch_pkg.sv
// Shared types of the fetch datapath and the cache interface FSM
`include "len5_consts.svh"

package fetch_pkg;

  // ----------------------------------------------------------------------
  // Cache interface FSM
  // ----------------------------------------------------------------------

  typedef enum logic [1:0] {
    // Waiting for a read request
    IFC_IDLE    = 2'd0,
    // Address offered to the cache
    IFC_REQ     = 2'd1,
    // Address accepted, waiting for the word
    IFC_WAIT    = 2'd2,
    // Draining a response killed by a flush
    IFC_DISCARD = 2'd3
  } icache_state_t;

  // ----------------------------------------------------------------------
  // Fetch buffer entry
  // ----------------------------------------------------------------------

  // Word, its PC and the prediction made for that PC
  typedef struct packed {
    logic [`ILEN-1:0] instr;
    logic [`XLEN-1:0] pc;
    logic             pred_taken;
    logic [`XLEN-1:0] pred_target;
  } fetch_entry_t;

endpackage

// File: verilog/bpu_pkg.sv
// Types and helpers of the BTB and gshare branch predictor
`include "len5_consts.svh"

package bpu_pkg;

  // Two-bit saturating direction counter
  typedef enum logic [1:0] {
    STRONG_NT = 2'd0,
    WEAK_NT   = 2'd1,
    WEAK_T    = 2'd2,
    STRONG_T  = 2'd3
  } sat_cnt_t;

  // BTB tag width for the default geometry
  // Word aligned PC, so the two low bits carry nothing
  localparam int btb_tag_w = `XLEN - `BTB_BITS_DEFAULT - 2;

  // Next counter state after a resolved outcome
  function automatic sat_cnt_t sat_next(input sat_cnt_t cnt, input logic taken);
    sat_cnt_t nxt;
    nxt = cnt;
    case (cnt)
      STRONG_NT: nxt = taken ? WEAK_NT : STRONG_NT;
      WEAK_NT:   nxt = taken ? WEAK_T : STRONG_NT;
      WEAK_T:    nxt = taken ? STRONG_T : WEAK_NT;
      STRONG_T:  nxt = taken ? STRONG_T : WEAK_T;
      default:   nxt = WEAK_NT;
    endcase
    return nxt;
  endfunction

  // Upper half of the counter range predicts taken
  function automatic logic sat_taken(input sat_cnt_t cnt);
    return (cnt == WEAK_T) || (cnt == STRONG_T);
  endfunction

endpackage

// File: verilog/icache_ifc.sv
// Instruction cache handshake controller with flush discard
`timescale 1ns/100ps
`include "len5_consts.svh"

module icache_ifc (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             flush_i,
  // Fetch unit side
  input  logic             read_req_i,
  input  logic [`XLEN-1:0] pc_i,
  output logic [`ILEN-1:0] rd_instr_o,
  output logic [`XLEN-1:0] rd_pc_o,
  output logic             read_done_o,
  // Instruction cache side
  output logic [`XLEN-1:0] addr_o,
  output logic             addr_valid_o,
  input  logic             addr_ready_i,
  input  logic [`ILEN-1:0] data_i,
  input  logic             data_valid_i,
  output logic             data_ready_o
);

  fetch_pkg::icache_state_t state_q, state_d;

  // Address of the read in progress
  logic [`XLEN-1:0] pc_q;
  // Request parked behind a discard
  logic [`XLEN-1:0] pend_pc_q;
  logic             pend_q;
  // Flush seen before the address was taken
  logic             kill_q;
  logic             addr_hs;
  logic             data_hs;
  logic             busy_req;
  logic             drain_done;

  // ----------------------------------------------------------------------
  // Handshakes
  // ----------------------------------------------------------------------

  assign addr_o       = pc_q;
  assign addr_valid_o = (state_q == fetch_pkg::IFC_REQ);
  // Discard state must also accept the late word
  assign data_ready_o = (state_q == fetch_pkg::IFC_WAIT) ||
                        (state_q == fetch_pkg::IFC_DISCARD);
  assign addr_hs      = addr_valid_o & addr_ready_i;
  assign data_hs      = data_valid_i & data_ready_o;

  // Only possible right after a flush
  assign busy_req     = read_req_i & (state_q != fetch_pkg::IFC_IDLE);
  // Stale word dropped, cache is free again
  assign drain_done   = (state_q == fetch_pkg::IFC_DISCARD) & data_hs;

  // ----------------------------------------------------------------------
  // Next state
  // ----------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      fetch_pkg::IFC_IDLE: begin
        if (read_req_i) begin
          state_d = fetch_pkg::IFC_REQ;
        end
      end
      fetch_pkg::IFC_REQ: begin
        // Killed address still has to reach the cache
        if (addr_hs) begin
          state_d = (flush_i | kill_q) ? fetch_pkg::IFC_DISCARD : fetch_pkg::IFC_WAIT;
        end
      end
      fetch_pkg::IFC_WAIT: begin
        // Word and flush together, word simply dropped
        if (data_hs) begin
          state_d = fetch_pkg::IFC_IDLE;
        end else if (flush_i) begin
          state_d = fetch_pkg::IFC_DISCARD;
        end
      end
      fetch_pkg::IFC_DISCARD: begin
        if (data_hs) begin
          state_d = ((pend_q | read_req_i) & ~flush_i) ? fetch_pkg::IFC_REQ
                                                        : fetch_pkg::IFC_IDLE;
        end
      end
      default: state_d = fetch_pkg::IFC_IDLE;
    endcase
  end

  // ----------------------------------------------------------------------
  // Control registers
  // ----------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= fetch_pkg::IFC_IDLE;
      kill_q      <= 1'b0;
      pend_q      <= 1'b0;
      read_done_o <= 1'b0;
    end else begin
      state_q     <= state_d;
      // One cycle after a live data handshake
      read_done_o <= (state_q == fetch_pkg::IFC_WAIT) & data_hs & ~flush_i;
      // Sticky while the killed address waits for ready
      kill_q      <= (state_q == fetch_pkg::IFC_REQ) & ~addr_hs & (kill_q | flush_i);
      if (flush_i || drain_done) begin
        pend_q <= 1'b0;
      end else if (busy_req) begin
        pend_q <= 1'b1;
      end
    end
  end

  // Address and returned word
  always_ff @(posedge clk_i) begin
    if ((state_q == fetch_pkg::IFC_IDLE) && read_req_i) begin
      pc_q <= pc_i;
    end else if (drain_done) begin
      pc_q <= pend_q ? pend_pc_q : pc_i;
    end
    if (busy_req) begin
      pend_pc_q <= pc_i;
    end
    if ((state_q == fetch_pkg::IFC_WAIT) && data_hs) begin
      rd_instr_o <= data_i;
      rd_pc_o    <= pc_q;
    end
  end

  // Cache sees a steady address until it takes it
  a_addr_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    addr_valid_o && !addr_ready_i |=> addr_valid_o && $stable(addr_o));

endmodule

// File: verilog/bpu.sv
// Branch predictor with a direct-mapped BTB and a gshare pattern table
`timescale 1ns/100ps
`include "len5_consts.svh"

module bpu #(
  parameter int HLEN     = `HLEN_DEFAULT,
  parameter int BTB_BITS = `BTB_BITS_DEFAULT
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             flush_i,
  // Fetch PC
  input  logic [`XLEN-1:0] pc_i,
  // Resolution from execute
  input  logic             res_valid_i,
  input  logic             res_taken_i,
  input  logic             res_mispredict_i,
  input  logic [`XLEN-1:0] res_pc_i,
  input  logic [`XLEN-1:0] res_target_i,
  // Prediction
  output logic             pred_taken_o,
  output logic [`XLEN-1:0] pred_target_o
);

  localparam int BTB_DEPTH = 2 ** BTB_BITS;
  localparam int PHT_DEPTH = 2 ** HLEN;
  // PC bits above the index
  localparam int TAG_W     = `XLEN - BTB_BITS - 2;

  // BTB columns
  logic              btb_valid_q [BTB_DEPTH];
  logic [TAG_W-1:0]  btb_tag_q   [BTB_DEPTH];
  logic [`XLEN-1:0]  btb_tgt_q   [BTB_DEPTH];
  // Direction counters
  bpu_pkg::sat_cnt_t pht_q       [PHT_DEPTH];
  // Global history, newest outcome in bit 0
  logic [HLEN-1:0]   ghr_q;

  logic [BTB_BITS-1:0] pred_btb_idx;
  logic [BTB_BITS-1:0] res_btb_idx;
  logic [HLEN-1:0]     pred_pht_idx;
  logic [HLEN-1:0]     res_pht_idx;
  logic                btb_hit;
  logic                clear_tables;

  // ----------------------------------------------------------------------
  // Prediction path
  // ----------------------------------------------------------------------

  assign pred_btb_idx = pc_i[BTB_BITS+1:2];
  // gshare hash of PC and history
  assign pred_pht_idx = pc_i[HLEN+1:2] ^ ghr_q;
  assign btb_hit      = btb_valid_q[pred_btb_idx] &&
                        (btb_tag_q[pred_btb_idx] == pc_i[`XLEN-1:BTB_BITS+2]);

  // Taken only with a known target
  assign pred_taken_o  = btb_hit && bpu_pkg::sat_taken(pht_q[pred_pht_idx]);
  assign pred_target_o = btb_tgt_q[pred_btb_idx];

  // ----------------------------------------------------------------------
  // Training path
  // ----------------------------------------------------------------------

  assign res_btb_idx  = res_pc_i[BTB_BITS+1:2];
  // Same hash, history as seen by the branch
  assign res_pht_idx  = res_pc_i[HLEN+1:2] ^ ghr_q;
  // Mispredict flush keeps what was learned
  assign clear_tables = flush_i & ~res_mispredict_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < BTB_DEPTH; i++) begin
        btb_valid_q[i] <= 1'b0;
      end
      for (int i = 0; i < PHT_DEPTH; i++) begin
        pht_q[i] <= bpu_pkg::WEAK_NT;
      end
      ghr_q <= '0;
    end else begin
      // Counters survive any flush
      if (res_valid_i) begin
        pht_q[res_pht_idx] <= bpu_pkg::sat_next(pht_q[res_pht_idx], res_taken_i);
      end
      if (clear_tables) begin
        for (int i = 0; i < BTB_DEPTH; i++) begin
          btb_valid_q[i] <= 1'b0;
        end
        ghr_q <= '0;
      end else if (res_valid_i) begin
        if (res_taken_i) begin
          btb_valid_q[res_btb_idx] <= 1'b1;
        end
        // Shift in the outcome
        ghr_q <= {ghr_q[HLEN-2:0], res_taken_i};
      end
    end
  end

  // Tag and target written by taken branches only
  always_ff @(posedge clk_i) begin
    if (res_valid_i && res_taken_i) begin
      btb_tag_q[res_btb_idx] <= res_pc_i[`XLEN-1:BTB_BITS+2];
      btb_tgt_q[res_btb_idx] <= res_target_i;
    end
  end

  // Execute stage flags a mispredict only on a resolved branch
  a_mispredict_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    res_mispredict_i |-> res_valid_i);

endmodule

// File: verilog/ifu.sv
// Fetch unit that starts cache reads and issues words from a two-entry buffer
`timescale 1ns/100ps
`include "len5_consts.svh"

module ifu (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             flush_i,
  // PC generator
  input  logic [`XLEN-1:0] pc_i,
  output logic             fetch_ready_o,
  // Prediction for pc_i
  input  logic             pred_taken_i,
  input  logic [`XLEN-1:0] pred_target_i,
  // Cache interface
  input  logic [`ILEN-1:0] rd_instr_i,
  input  logic [`XLEN-1:0] rd_pc_i,
  input  logic             read_done_i,
  output logic             read_req_o,
  // Decode
  input  logic             issue_ready_i,
  output logic             issue_valid_o,
  output logic [`ILEN-1:0] instruction_o,
  output logic [`XLEN-1:0] issue_pc_o,
  output logic             pred_taken_o,
  output logic [`XLEN-1:0] pred_target_o
);

  localparam int DEPTH = 2;

  fetch_pkg::fetch_entry_t buf_q [DEPTH];

  logic       rd_ptr_q;
  logic       wr_ptr_q;
  logic [1:0] count_q;
  // One read in the cache at most
  logic       outst_q;
  logic       push;
  logic       pop;
  logic       space;

  // ----------------------------------------------------------------------
  // Read start and completion
  // ----------------------------------------------------------------------

  // Word returned by a read that a flush did not kill
  assign push          = read_done_i & ~flush_i;
  assign pop           = issue_valid_o & issue_ready_i;
  // Free slot now, or one freed by this pop
  assign space         = (count_q < 2'(DEPTH)) | pop;
  assign read_req_o    = ~outst_q & space & ~flush_i;
  // pc_i captured, generator may step
  assign fetch_ready_o = push;

  // ----------------------------------------------------------------------
  // Buffer head to decode
  // ----------------------------------------------------------------------

  assign issue_valid_o = (count_q != 2'd0);
  assign instruction_o = buf_q[rd_ptr_q].instr;
  assign issue_pc_o    = buf_q[rd_ptr_q].pc;
  assign pred_taken_o  = buf_q[rd_ptr_q].pred_taken;
  assign pred_target_o = buf_q[rd_ptr_q].pred_target;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_ptr_q <= 1'b0;
      wr_ptr_q <= 1'b0;
      count_q  <= 2'd0;
      outst_q  <= 1'b0;
    end else if (flush_i) begin
      // Empty buffer, stale read left to the cache interface
      rd_ptr_q <= 1'b0;
      wr_ptr_q <= 1'b0;
      count_q  <= 2'd0;
      outst_q  <= 1'b0;
    end else begin
      if (read_req_o) begin
        outst_q <= 1'b1;
      end else if (read_done_i) begin
        outst_q <= 1'b0;
      end
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Prediction still valid, pc_i is held until fetch_ready_o
  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_q[wr_ptr_q] <= '{instr:       rd_instr_i,
                           pc:          rd_pc_i,
                           pred_taken:  pred_taken_i,
                           pred_target: pred_target_i};
    end
  end

  // Lookahead on the pop never lets a third entry in
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    push |-> (count_q < 2'(DEPTH)) || pop);

  // Returned word belongs to the PC the generator still holds
  a_pc_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    push |-> rd_pc_i == pc_i);

endmodule

// File: verilog/fetch_stage.sv
// Instruction fetch stage joining the cache interface, predictor and fetch unit
`timescale 1ns/100ps
`include "len5_consts.svh"

module fetch_stage #(
  parameter int HLEN     = `HLEN_DEFAULT,
  parameter int BTB_BITS = `BTB_BITS_DEFAULT
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             flush_i,
  // PC generator
  input  logic [`XLEN-1:0] pc_i,
  output logic             fetch_ready_o,
  // Instruction cache
  output logic [`XLEN-1:0] addr_o,
  output logic             addr_valid_o,
  input  logic             addr_ready_i,
  input  logic [`ILEN-1:0] data_i,
  input  logic             data_valid_i,
  output logic             data_ready_o,
  // Decode
  input  logic             issue_ready_i,
  output logic             issue_valid_o,
  output logic [`ILEN-1:0] instruction_o,
  output logic [`XLEN-1:0] issue_pc_o,
  output logic             pred_taken_o,
  output logic [`XLEN-1:0] pred_target_o,
  // Branch resolution from execute
  input  logic             res_valid_i,
  input  logic             res_taken_i,
  input  logic             res_mispredict_i,
  input  logic [`XLEN-1:0] res_pc_i,
  input  logic [`XLEN-1:0] res_target_i
);

  // Fetch unit and cache interface
  logic             read_req;
  logic             read_done;
  logic [`ILEN-1:0] rd_instr;
  logic [`XLEN-1:0] rd_pc;
  // Predictor to fetch unit
  logic             pred_taken;
  logic [`XLEN-1:0] pred_target;

  // ----------------------------------------------------------------------
  // Cache interface
  // ----------------------------------------------------------------------

  icache_ifc u_icache_ifc (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .flush_i      (flush_i),
    .read_req_i   (read_req),
    .pc_i         (pc_i),
    .rd_instr_o   (rd_instr),
    .rd_pc_o      (rd_pc),
    .read_done_o  (read_done),
    .addr_o       (addr_o),
    .addr_valid_o (addr_valid_o),
    .addr_ready_i (addr_ready_i),
    .data_i       (data_i),
    .data_valid_i (data_valid_i),
    .data_ready_o (data_ready_o)
  );

  // ----------------------------------------------------------------------
  // Branch predictor, decides on its own which flushes clear it
  // ----------------------------------------------------------------------

  bpu #(
    .HLEN     (HLEN),
    .BTB_BITS (BTB_BITS)
  ) u_bpu (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .flush_i          (flush_i),
    .pc_i             (pc_i),
    .res_valid_i      (res_valid_i),
    .res_taken_i      (res_taken_i),
    .res_mispredict_i (res_mispredict_i),
    .res_pc_i         (res_pc_i),
    .res_target_i     (res_target_i),
    .pred_taken_o     (pred_taken),
    .pred_target_o    (pred_target)
  );

  // ----------------------------------------------------------------------
  // Fetch unit
  // ----------------------------------------------------------------------

  ifu u_ifu (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .flush_i       (flush_i),
    .pc_i          (pc_i),
    .fetch_ready_o (fetch_ready_o),
    .pred_taken_i  (pred_taken),
    .pred_target_i (pred_target),
    .rd_instr_i    (rd_instr),
    .rd_pc_i       (rd_pc),
    .read_done_i   (read_done),
    .read_req_o    (read_req),
    .issue_ready_i (issue_ready_i),
    .issue_valid_o (issue_valid_o),
    .instruction_o (instruction_o),
    .issue_pc_o    (issue_pc_o),
    .pred_taken_o  (pred_taken_o),
    .pred_target_o (pred_target_o)
  );

endmodule

// File: tests/tb_fetch_stage.sv
// Fetch stage testbench with cache, PC generator and branch predictor reference models
`timescale 1ns/100ps
`include "len5_consts.svh"

module tb_fetch_stage;

  localparam int          CLK_PERIOD = 40;
  localparam int          DRIVE_DLY  = 2;
  localparam int          HLEN       = `HLEN_DEFAULT;
  localparam int          BTB_BITS   = `BTB_BITS_DEFAULT;
  localparam int          BTB_N      = 2 ** BTB_BITS;
  localparam int          PHT_N      = 2 ** HLEN;
  localparam int          TAG_W      = bpu_pkg::btb_tag_w;
  localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
  localparam logic [31:0] START_PC   = 32'h0000_1000;
  localparam logic [31:0] FLUSH_PC   = 32'h0000_4000;
  // Branch far enough ahead of the stream to train it first
  localparam logic [31:0] BR_PC      = 32'h0000_4100;
  localparam logic [31:0] BR_TARGET  = 32'h0000_6000;

  logic             clk_i;
  logic             arst_n_i;
  logic             flush_i;
  logic [`XLEN-1:0] pc_i;
  logic             fetch_ready_o;
  logic [`XLEN-1:0] addr_o;
  logic             addr_valid_o;
  logic             addr_ready_i;
  logic [`ILEN-1:0] data_i;
  logic             data_valid_i;
  logic             data_ready_o;
  logic             issue_ready_i;
  logic             issue_valid_o;
  logic [`ILEN-1:0] instruction_o;
  logic [`XLEN-1:0] issue_pc_o;
  logic             pred_taken_o;
  logic [`XLEN-1:0] pred_target_o;
  logic             res_valid_i;
  logic             res_taken_i;
  logic             res_mispredict_i;
  logic [`XLEN-1:0] res_pc_i;
  logic [`XLEN-1:0] res_target_i;

  // Stimulus state
  logic [31:0]      lfsr_q;
  logic             hold_issue;
  logic             cache_hold;
  logic             jump_req;
  logic [`XLEN-1:0] jump_pc;
  logic             fr_seen;
  logic [`XLEN-1:0] addr_q [$];
  logic [1:0]       lat_q [$];
  // Scoreboard state
  string            test_name;
  logic [`XLEN-1:0] next_pc;
  logic             exp_taken_q [$];
  logic [`XLEN-1:0] exp_tgt_q [$];
  int               issue_count;
  int               fetch_count;
  logic             watch_seen;
  logic             watch_taken;
  // Reference predictor
  logic              m_valid [BTB_N];
  logic [TAG_W-1:0]  m_tag [BTB_N];
  logic [`XLEN-1:0]  m_tgt [BTB_N];
  bpu_pkg::sat_cnt_t m_cnt [PHT_N];
  logic [HLEN-1:0]   m_ghr;

  fetch_stage dut_i (.*);

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  // Cache contents scrambled over the whole address
  function automatic logic [`ILEN-1:0] instr_of(input logic [`XLEN-1:0] pc);
    return (pc * 32'h9e37_79b1) ^ {pc[15:0], pc[31:16]};
  endfunction

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ({1'b0, s[31:1]} ^ LFSR_TAPS) : {1'b0, s[31:1]};
  endfunction

  function automatic logic rand_bit();
    lfsr_q = lfsr_next(lfsr_q);
    return lfsr_q[0];
  endfunction

  // Two-bit counter saturating at both ends
  function automatic bpu_pkg::sat_cnt_t cnt_after(input bpu_pkg::sat_cnt_t cnt,
                                                  input logic taken);
    if (taken && (cnt != bpu_pkg::STRONG_T)) begin
      return bpu_pkg::sat_cnt_t'(cnt + 2'd1);
    end
    if (!taken && (cnt != bpu_pkg::STRONG_NT)) begin
      return bpu_pkg::sat_cnt_t'(cnt - 2'd1);
    end
    return cnt;
  endfunction

  // Taken needs a BTB hit and an upper-half counter
  function automatic logic model_taken(input logic [`XLEN-1:0] pc);
    logic [BTB_BITS-1:0] bidx;
    bpu_pkg::sat_cnt_t   cnt;
    bidx = pc[BTB_BITS+1:2];
    cnt  = m_cnt[pc[HLEN+1:2] ^ m_ghr];
    return m_valid[bidx] && (m_tag[bidx] == pc[`XLEN-1:BTB_BITS+2]) &&
           ((cnt == bpu_pkg::WEAK_T) || (cnt == bpu_pkg::STRONG_T));
  endfunction

  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s %s expected %h actual %h", test_name, what, expected, actual);
      abort_run();
    end
  endtask

  task automatic report_timeout(input string what);
    fetch_pkg::icache_state_t ifc_state;
    ifc_state = dut_i.u_icache_ifc.state_q;
    $display("ERROR: timed out waiting for %s, cache interface in %s", what,
             ifc_state.name());
    abort_run();
  endtask

  // ----------------------------------------------------------------------
  // Clock and input drivers
  // ----------------------------------------------------------------------

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Decisions taken from values sampled at the falling edge
  always @(posedge clk_i) begin : drive
    #DRIVE_DLY;
    // PC generator where a jump wins over the step
    if (jump_req) begin
      pc_i     = jump_pc;
      jump_req = 1'b0;
    end else if (fr_seen) begin
      pc_i = pc_i + 32'd4;
    end
    addr_ready_i  = rand_bit();
    issue_ready_i = hold_issue ? 1'b0 : (rand_bit() | rand_bit());
    // Cache answers the oldest address after its latency
    data_valid_i = 1'b0;
    if ((addr_q.size() != 0) && !cache_hold) begin
      if (lat_q[0] != 2'd0) begin
        lat_q[0] = lat_q[0] - 2'd1;
      end else begin
        data_valid_i = rand_bit();
      end
      data_i = instr_of(addr_q[0]);
    end
  end

  // Cache handshakes as seen by the next rising edge
  always @(negedge clk_i) begin : cache_sample
    logic [1:0] lat;
    if (!arst_n_i) begin
      addr_q.delete();
      lat_q.delete();
      fr_seen = 1'b0;
    end else begin
      if (data_valid_i && data_ready_o) begin
        void'(addr_q.pop_front());
        void'(lat_q.pop_front());
      end
      if (addr_valid_o && addr_ready_i) begin
        lat = {rand_bit(), rand_bit()};
        addr_q.push_back(addr_o);
        lat_q.push_back(lat);
      end
      fr_seen = fetch_ready_o;
    end
  end

  // ----------------------------------------------------------------------
  // Comparison and reference predictor
  // ----------------------------------------------------------------------

  always @(negedge clk_i) begin : score
    logic [BTB_BITS-1:0] bidx;
    logic [HLEN-1:0]     pidx;
    logic                exp_taken;
    logic [`XLEN-1:0]    exp_tgt;
    if (!arst_n_i) begin
      for (int i = 0; i < BTB_N; i++) begin
        m_valid[i] = 1'b0;
      end
      for (int i = 0; i < PHT_N; i++) begin
        m_cnt[i] = bpu_pkg::WEAK_NT;
      end
      m_ghr   = '0;
      next_pc = START_PC;
    end else begin
      // Issued word against the expected PC stream
      if (issue_valid_o && issue_ready_i) begin
        if (exp_taken_q.size() == 0) begin
          $display("ERROR: word at %h issued without a completed fetch", issue_pc_o);
          abort_run();
        end
        exp_taken = exp_taken_q.pop_front();
        exp_tgt   = exp_tgt_q.pop_front();
        check_value("issue_pc", next_pc, issue_pc_o);
        check_value("instruction", instr_of(next_pc), instruction_o);
        check_value("pred_taken", exp_taken, pred_taken_o);
        if (exp_taken) begin
          check_value("pred_target", exp_tgt, pred_target_o);
        end
        if (issue_pc_o == BR_PC) begin
          watch_seen  = 1'b1;
          watch_taken = pred_taken_o;
        end
        next_pc     = next_pc + 32'd4;
        issue_count = issue_count + 1;
      end
      // Prediction as it stands while the word returns
      if (fetch_ready_o) begin
        exp_taken_q.push_back(model_taken(pc_i));
        exp_tgt_q.push_back(m_tgt[pc_i[BTB_BITS+1:2]]);
        fetch_count = fetch_count + 1;
      end
      // Buffered words die and the stream restarts at the new PC
      if (flush_i) begin
        exp_taken_q.delete();
        exp_tgt_q.delete();
        next_pc = pc_i;
      end
      // Table updates seen from the next cycle on
      bidx = res_pc_i[BTB_BITS+1:2];
      pidx = res_pc_i[HLEN+1:2] ^ m_ghr;
      if (res_valid_i) begin
        m_cnt[pidx] = cnt_after(m_cnt[pidx], res_taken_i);
      end
      if (flush_i && !res_mispredict_i) begin
        for (int i = 0; i < BTB_N; i++) begin
          m_valid[i] = 1'b0;
        end
        m_ghr = '0;
      end else if (res_valid_i) begin
        if (res_taken_i) begin
          m_valid[bidx] = 1'b1;
          m_tag[bidx]   = res_pc_i[`XLEN-1:BTB_BITS+2];
          m_tgt[bidx]   = res_target_i;
        end
        m_ghr = {m_ghr[HLEN-2:0], res_taken_i};
      end
    end
  end

  // ----------------------------------------------------------------------
  // Sequence helpers
  // ----------------------------------------------------------------------

  task automatic wait_issue_count(input int target, input int limit, input string what);
    int cycles;
    cycles = 0;
    while (issue_count < target) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > limit) begin
        report_timeout(what);
      end
    end
  endtask

  // Fetched words not yet issued
  task automatic wait_buffered(input int target, input int limit, input string what);
    int cycles;
    cycles = 0;
    while (exp_taken_q.size() < target) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > limit) begin
        report_timeout(what);
      end
    end
  endtask

  task automatic wait_branch_issue(input int limit, input string what);
    int cycles;
    cycles = 0;
    while (!watch_seen) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > limit) begin
        report_timeout(what);
      end
    end
  endtask

  // Read in the cache with its address taken
  task automatic wait_data_ready(input int limit);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!data_ready_o) begin
      cycles++;
      if (cycles > limit) begin
        report_timeout("an outstanding cache read");
      end
      @(negedge clk_i);
    end
  endtask

  // One-cycle flush with the PC generator redirected in the same cycle
  task automatic flush_to(input logic [`XLEN-1:0] pc, input logic mispredict);
    @(negedge clk_i);
    jump_pc  = pc;
    jump_req = 1'b1;
    @(posedge clk_i);
    #DRIVE_DLY;
    flush_i          = 1'b1;
    res_valid_i      = mispredict;
    res_mispredict_i = mispredict;
    res_taken_i      = 1'b1;
    res_pc_i         = pc;
    res_target_i     = BR_TARGET;
    @(posedge clk_i);
    #DRIVE_DLY;
    flush_i          = 1'b0;
    res_valid_i      = 1'b0;
    res_mispredict_i = 1'b0;
  endtask

  task automatic train_branch(input logic [`XLEN-1:0] pc, input logic [`XLEN-1:0] target,
                              input int times);
    repeat (times) begin
      @(posedge clk_i);
      #DRIVE_DLY;
      res_valid_i  = 1'b1;
      res_taken_i  = 1'b1;
      res_pc_i     = pc;
      res_target_i = target;
    end
    @(posedge clk_i);
    #DRIVE_DLY;
    res_valid_i = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------

  initial begin : test_seq
    int base;
    arst_n_i         = 1'b0;
    flush_i          = 1'b0;
    pc_i             = START_PC;
    addr_ready_i     = 1'b0;
    data_i           = '0;
    data_valid_i     = 1'b0;
    issue_ready_i    = 1'b0;
    res_valid_i      = 1'b0;
    res_taken_i      = 1'b0;
    res_mispredict_i = 1'b0;
    res_pc_i         = '0;
    res_target_i     = '0;
    lfsr_q           = 32'hc090_4eb6;
    hold_issue       = 1'b0;
    cache_hold       = 1'b0;
    jump_req         = 1'b0;
    jump_pc          = '0;
    issue_count      = 0;
    fetch_count      = 0;
    watch_seen       = 1'b0;
    watch_taken      = 1'b0;
    test_name        = "reset";
    repeat (8) @(posedge clk_i);
    // Handshake outputs quiet under reset
    check_value("addr_valid_o", 1'b0, addr_valid_o);
    check_value("data_ready_o", 1'b0, data_ready_o);
    check_value("issue_valid_o", 1'b0, issue_valid_o);
    check_value("fetch_ready_o", 1'b0, fetch_ready_o);
    #DRIVE_DLY;
    arst_n_i = 1'b1;

    test_name = "random_stream";
    wait_issue_count(40, 2000, "40 words under random stalls");

    // Decode stalled until the buffer fills and fetching stops
    test_name = "backpressure";
    @(posedge clk_i);
    hold_issue = 1'b1;
    base       = fetch_count;
    wait_buffered(2, 200, "the fetch buffer to fill");
    repeat (20) @(posedge clk_i);
    if (fetch_count - base > 3) begin
      $display("ERROR: %0d fetches completed while decode was stalled", fetch_count - base);
      abort_run();
    end
    check_value("buffered_words", 2, exp_taken_q.size());
    base       = issue_count + exp_taken_q.size();
    hold_issue = 1'b0;
    wait_issue_count(base, 200, "buffered words to drain");

    // Stale response held in the cache across the flush
    test_name  = "flush_discard";
    cache_hold = 1'b1;
    wait_data_ready(200);
    flush_to(FLUSH_PC, 1'b0);
    @(posedge clk_i);
    cache_hold = 1'b0;
    wait_issue_count(issue_count + 6, 400, "words after the flush");

    test_name  = "bpu_train";
    watch_seen = 1'b0;
    train_branch(BR_PC, BR_TARGET, 6);
    wait_branch_issue(4000, "the trained branch to issue");
    check_value("trained_taken", 1'b1, watch_taken);

    test_name  = "flush_keep";
    watch_seen = 1'b0;
    flush_to(BR_PC, 1'b1);
    wait_branch_issue(400, "the branch after a mispredict flush");
    check_value("kept_taken", 1'b1, watch_taken);

    test_name  = "flush_clear";
    watch_seen = 1'b0;
    flush_to(BR_PC, 1'b0);
    wait_branch_issue(400, "the branch after a plain flush");
    check_value("cleared_not_taken", 1'b0, watch_taken);
    wait_issue_count(issue_count + 8, 400, "words after the last flush");

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: len5_fetch.f
+incdir+include
verilog/fetch_pkg.sv
verilog/bpu_pkg.sv
verilog/icache_ifc.sv
verilog/bpu.sv
verilog/ifu.sv
verilog/fetch_stage.sv
tests/tb_fetch_stage.sv
